//--- common/mmu_config.svh
// Fixed MMU widths, tag bit positions and table sizes
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// --------------------------------------------------
// Address layout
// --------------------------------------------------
`define MMU_PAGE_BITS        10     // Page number, map has 1024 entries
`define MMU_OFFSET_BITS      10     // Word offset in a page
`define MMU_VADDR_BITS       20     // Virtual and physical address
`define MMU_BESM6_PAGE_BITS  5      // Page number in BESM-6 mode

// --------------------------------------------------
// Word tag
// --------------------------------------------------
`define MMU_TAG_BITS         8
`define MMU_TAG_CMD          0      // Instruction word marker
`define MMU_TAG_BESM6        1      // BESM-6 compatibility
`define MMU_TAG_NOLOAD       2      // Operand read protect
`define MMU_TAG_NOFETCH      4      // Instruction fetch protect
`define MMU_TAG_NOJUMP       5      // Jump target protect
`define MMU_TAG_PINT         7      // Software tag interpretation

`endif

//--- common/mmu_pkg.sv
// MMU types: page, address and tag words, arbiter opcodes, trap vectors
`default_nettype none

`include "mmu_config.svh"

package mmu_pkg;

    typedef logic [`MMU_PAGE_BITS-1:0]  page_t;
    typedef logic [`MMU_VADDR_BITS-1:0] vaddr_t;
    typedef logic [`MMU_TAG_BITS-1:0]   tag_t;

    // Bus arbiter opcodes
    typedef enum logic [3:0] {
        NOP   = 4'd0,
        CCRD  = 4'd1,       // Instruction cache read
        CCWR  = 4'd2,       // Instruction cache write
        DCRD  = 4'd3,       // Data cache read
        DCWR  = 4'd4,       // Data cache write
        DRD   = 4'd9,       // Direct read
        DWR   = 4'd10,      // Result write
        RDMWR = 4'd11,      // Read-modify-write
        BTRWR = 4'd12       // Block transfer write
    } arb_op_t;

    // Opcodes that mark the page as modified
    function automatic logic is_write_op(arb_op_t op);
        return op inside {CCWR, DCWR, DWR, RDMWR, BTRWR};
    endfunction

    // Tag-check interrupt vectors
    typedef enum logic [4:0] {
        NONE       = 5'd0,
        PINT_INSTR = 5'd9,
        PINT_DATA  = 5'd10,
        READ_PROT  = 5'd11,
        NOT_CMD    = 5'd12,
        FETCH_PROT = 5'd18,
        JUMP_PROT  = 5'd19,
        BAD_ACC    = 5'd21,
        BAD_OP     = 5'd22
    } trap_vect_t;

endpackage

`default_nettype wire

//--- hdl/mmu_top.sv
// MMU subsystem top: page map, page status and tag-check blocks
`default_nettype none
`timescale 1ns/100ps

module mmu_top (
    input  wire                  clk,
    input  wire                  reset,
    // Page map
    input  wire                  i_map_we,
    input  wire mmu_pkg::page_t  i_map_index,
    input  wire mmu_pkg::page_t  i_map_data,
    input  wire mmu_pkg::vaddr_t i_vaddr,
    input  wire                  i_no_paging,
    // Page status
    input  wire                  i_req,
    input  wire mmu_pkg::arb_op_t i_arb_op,
    input  wire                  i_page_we,
    input  wire mmu_pkg::page_t  i_page_data,
    input  wire                  i_stat_we,
    input  wire                  i_stat_used,
    input  wire                  i_stat_dirty,
    input  wire                  i_reprio_we,
    input  wire                  i_reprio_bit,
    input  wire                  i_fill_start,
    // Tags
    input  wire                  i_fetch_done,
    input  wire                  i_load_done,
    input  wire mmu_pkg::tag_t   i_tag,
    input  wire                  i_acc_we,
    input  wire                  i_acc_besm6,
    input  wire                  i_mode_set,
    input  wire                  i_mode_clr,
    input  wire                  i_flag_jump,
    input  wire                  i_no_progtag,
    input  wire                  i_no_rtag,
    input  wire                  i_no_badacc,
    input  wire                  i_no_badop,
    input  wire                  i_int_clear,
    output mmu_pkg::vaddr_t      o_physad,
    output mmu_pkg::page_t       o_page,
    output logic                 o_used,
    output logic                 o_dirty,
    output logic                 o_reprio,
    output logic                 o_fill_busy,
    output logic                 o_besm6_mode,
    output logic                 o_int_pending,
    output mmu_pkg::trap_vect_t  o_int_vect
);
    import mmu_pkg::*;

    page_t xlat_page;                       // Combinational translated page

    page_map u_page_map (
        .clk(clk), .i_map_we(i_map_we), .i_map_index(i_map_index),
        .i_map_data(i_map_data), .i_vaddr(i_vaddr), .i_mode(o_besm6_mode),
        .i_no_paging(i_no_paging), .o_xlat_page(xlat_page), .o_physad(o_physad)
    );

    page_status u_page_status (
        .clk(clk), .reset(reset), .i_req(i_req), .i_arb_op(i_arb_op),
        .i_xlat_page(xlat_page), .i_page_we(i_page_we), .i_page_data(i_page_data),
        .i_stat_we(i_stat_we), .i_stat_used(i_stat_used), .i_stat_dirty(i_stat_dirty),
        .i_reprio_we(i_reprio_we), .i_reprio_bit(i_reprio_bit),
        .i_fill_start(i_fill_start), .o_page(o_page), .o_used(o_used),
        .o_dirty(o_dirty), .o_reprio(o_reprio), .o_fill_busy(o_fill_busy)
    );

    tag_trap u_tag_trap (
        .clk(clk), .reset(reset), .i_fetch_done(i_fetch_done), .i_load_done(i_load_done),
        .i_tag(i_tag), .i_acc_we(i_acc_we), .i_acc_besm6(i_acc_besm6),
        .i_mode_set(i_mode_set), .i_mode_clr(i_mode_clr), .i_flag_jump(i_flag_jump),
        .i_no_progtag(i_no_progtag), .i_no_rtag(i_no_rtag), .i_no_badacc(i_no_badacc),
        .i_no_badop(i_no_badop), .i_int_clear(i_int_clear), .o_mode(o_besm6_mode),
        .o_int_pending(o_int_pending), .o_int_vect(o_int_vect)
    );

endmodule

`default_nettype wire

//--- hdl/tag_trap.sv
// BESM-6 mode flag, accumulator tag and tag-check trap latch
`default_nettype none
`timescale 1ns/100ps

`include "mmu_config.svh"

module tag_trap (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 i_fetch_done,   // Instruction word fetched
    input  wire                 i_load_done,    // Operand loaded
    input  wire mmu_pkg::tag_t  i_tag,
    input  wire                 i_acc_we,       // Accumulator tag write
    input  wire                 i_acc_besm6,
    input  wire                 i_mode_set,
    input  wire                 i_mode_clr,
    input  wire                 i_flag_jump,    // Previous instruction was a jump
    input  wire                 i_no_progtag,   // Masks for the tag checks
    input  wire                 i_no_rtag,
    input  wire                 i_no_badacc,
    input  wire                 i_no_badop,
    input  wire                 i_int_clear,
    output logic                o_mode,
    output logic                o_int_pending,
    output mmu_pkg::trap_vect_t o_int_vect
);
    import mmu_pkg::*;

    logic       acc_besm6;                      // BESM-6 bit of accumulator tag
    logic       tag_mismatch;
    trap_vect_t trap_vect;

    // --------------------------------------------------
    // Mode and accumulator tag
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            o_mode <= 1'b0;
        else if (i_fetch_done)
            o_mode <= i_tag[`MMU_TAG_BESM6];    // Follows instruction tag
        else if (i_mode_set)
            o_mode <= 1'b1;
        else if (i_mode_clr)
            o_mode <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset)
            acc_besm6 <= 1'b0;
        else if (i_acc_we)
            acc_besm6 <= i_acc_besm6;
    end

    // --------------------------------------------------
    // Tag checks in priority order
    // --------------------------------------------------
    assign tag_mismatch = i_tag[`MMU_TAG_BESM6] != acc_besm6;

    always_comb begin
        trap_vect = NONE;
        if (i_fetch_done && i_tag[`MMU_TAG_PINT] && !i_no_progtag)
            trap_vect = PINT_INSTR;
        else if (i_load_done && i_tag[`MMU_TAG_PINT] && !i_no_progtag)
            trap_vect = PINT_DATA;
        else if (i_load_done && i_tag[`MMU_TAG_NOLOAD] && !i_no_rtag)
            trap_vect = READ_PROT;
        else if (i_fetch_done && !i_tag[`MMU_TAG_CMD])
            trap_vect = NOT_CMD;
        else if (i_fetch_done && i_tag[`MMU_TAG_NOFETCH])
            trap_vect = FETCH_PROT;
        else if (i_fetch_done && i_tag[`MMU_TAG_NOJUMP] && i_flag_jump)
            trap_vect = JUMP_PROT;
        else if (i_fetch_done && tag_mismatch && !i_no_badacc)
            trap_vect = BAD_ACC;                // Foreign accumulator
        else if (i_load_done && tag_mismatch && !i_no_badop)
            trap_vect = BAD_OP;                 // Foreign operand
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_int_pending <= 1'b0;
            o_int_vect    <= NONE;
        end else if (trap_vect != NONE) begin
            o_int_pending <= 1'b1;              // Trap wins over clear
            o_int_vect    <= trap_vect;
        end else if (i_int_clear) begin
            o_int_pending <= 1'b0;
        end
    end

    // Fetch and load share one exchange register path
    a_one_strobe: assert property (
        @(posedge clk) disable iff (reset) !(i_fetch_done && i_load_done)
    ) else $error("fetch and load strobes together");

endmodule

`default_nettype wire

//--- mmu.f
+incdir+common
+incdir+verification
common/mmu_pkg.sv
paging/page_map.sv
paging/page_status.sv
hdl/tag_trap.sv
hdl/mmu_top.sv
verification/mmu_tb.sv

//--- paging/page_map.sv
// Page map memory and virtual to physical address translation
`default_nettype none
`timescale 1ns/100ps

`include "mmu_config.svh"

module page_map (
    input  wire             clk,
    input  wire             i_map_we,       // Map entry write strobe
    input  wire mmu_pkg::page_t  i_map_index,
    input  wire mmu_pkg::page_t  i_map_data,
    input  wire mmu_pkg::vaddr_t i_vaddr,
    input  wire             i_mode,         // BESM-6 mode, short page number
    input  wire             i_no_paging,    // Bypass the map
    output mmu_pkg::page_t  o_xlat_page,
    output mmu_pkg::vaddr_t o_physad
);
    import mmu_pkg::*;

    page_t map_mem [1 << `MMU_PAGE_BITS];   // One physical page per virtual page
    page_t virt_page;

    // --------------------------------------------------
    // Map write
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_map_we)
            map_mem[i_map_index] <= i_map_data;
    end

    // --------------------------------------------------
    // Translation
    // --------------------------------------------------
    always_comb begin
        if (i_mode)
            virt_page = {{(`MMU_PAGE_BITS - `MMU_BESM6_PAGE_BITS){1'b0}},
                         i_vaddr[`MMU_OFFSET_BITS +: `MMU_BESM6_PAGE_BITS]};    // 15-bit space
        else
            virt_page = i_vaddr[`MMU_OFFSET_BITS +: `MMU_PAGE_BITS];            // Full space
    end

    assign o_xlat_page = i_no_paging ? virt_page : map_mem[virt_page];
    assign o_physad    = {o_xlat_page, i_vaddr[`MMU_OFFSET_BITS-1:0]};   // Offset passes through

    // A write to an unknown index would corrupt an arbitrary entry
    a_map_index_known: assert property (
        @(posedge clk) i_map_we |-> !$isunknown(i_map_index)
    ) else $error("page map written with unknown index");

endmodule

`default_nettype wire

//--- paging/page_status.sv
// Current physical page register, used/dirty/reprioritize bits, reprioritize fill
`default_nettype none
`timescale 1ns/100ps

`include "mmu_config.svh"

module page_status (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  i_req,         // Bus request strobe
    input  wire mmu_pkg::arb_op_t i_arb_op,
    input  wire mmu_pkg::page_t  i_xlat_page,   // Translated page of the request
    input  wire                  i_page_we,     // Explicit current page load
    input  wire mmu_pkg::page_t  i_page_data,
    input  wire                  i_stat_we,     // Used/dirty write for current page
    input  wire                  i_stat_used,
    input  wire                  i_stat_dirty,
    input  wire                  i_reprio_we,   // Reprioritize write for current page
    input  wire                  i_reprio_bit,
    input  wire                  i_fill_start,  // Start fill of reprio bits with ones
    output mmu_pkg::page_t       o_page,
    output logic                 o_used,
    output logic                 o_dirty,
    output logic                 o_reprio,
    output logic                 o_fill_busy
);
    import mmu_pkg::*;

    page_t cur_page;                                // Physical page register
    logic  pg_used   [1 << `MMU_PAGE_BITS];         // Page referenced
    logic  pg_dirty  [1 << `MMU_PAGE_BITS];         // Page modified
    logic  pg_reprio [1 << `MMU_PAGE_BITS];         // Reprioritize request
    logic  fill_busy;
    page_t fill_cnt;                                // Page being filled

    // --------------------------------------------------
    // Current page
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            cur_page <= '0;
        else if (i_req)
            cur_page <= i_xlat_page;                // Request beats explicit load
        else if (i_page_we)
            cur_page <= i_page_data;
    end

    // Request overrides the status write for used and dirty bits
    always_ff @(posedge clk) begin
        if (i_stat_we) begin
            pg_used[cur_page]  <= i_stat_used;
            pg_dirty[cur_page] <= i_stat_dirty;
        end
        if (i_req) begin
            pg_used[i_xlat_page] <= 1'b1;
            if (is_write_op(i_arb_op))
                pg_dirty[i_xlat_page] <= 1'b1;
        end
    end

    // --------------------------------------------------
    // Reprioritize fill
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_busy <= 1'b0;
            fill_cnt  <= '0;
        end else if (i_fill_start && !fill_busy) begin
            fill_busy <= 1'b1;
            fill_cnt  <= cur_page;                  // Walk from current page upward
        end else if (fill_busy) begin
            if (&fill_cnt)
                fill_busy <= 1'b0;                  // Top page done
            else
                fill_cnt <= fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_busy)
            pg_reprio[fill_cnt] <= 1'b1;
        else if (i_reprio_we)
            pg_reprio[cur_page] <= i_reprio_bit;    // Locked out during fill
    end

    assign o_page      = cur_page;
    assign o_used      = pg_used[cur_page];
    assign o_dirty     = pg_dirty[cur_page];
    assign o_reprio    = pg_reprio[cur_page];
    assign o_fill_busy = fill_busy;

    a_no_restart: assert property (
        @(posedge clk) disable iff (reset) i_fill_start |-> !fill_busy
    ) else $error("fill started while busy");

    // Page 0 after a busy cycle would mean the counter ran past the top page
    a_no_wrap: assert property (
        @(posedge clk) disable iff (reset) (fill_busy && $past(fill_busy)) |-> fill_cnt != '0
    ) else $error("fill counter wrapped");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the MMU testbench with Verilator and run it
# The simulator exits non-zero on $fatal, which fails the script
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module mmu_tb -f mmu.f -o mmu_sim

./obj_dir/mmu_sim

//--- verification/mmu_tb_tasks.svh
// Directed MMU tests with model map, model reprio bits and wait helpers
`ifndef MMU_TB_TASKS_SVH
`define MMU_TB_TASKS_SVH

page_t      model_map    [1 << `MMU_PAGE_BITS];     // Expected map contents
logic       model_reprio [1 << `MMU_PAGE_BITS];     // Expected reprio bits
logic       model_pending;
trap_vect_t model_vect;
arb_op_t    op_list [8] = '{CCRD, CCWR, DCRD, DCWR, DRD, DWR, RDMWR, BTRWR};

// --------------------------------------------------
// Checks and small drivers
// --------------------------------------------------
task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on first error");
endtask

task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        stop_run();
    end
endtask

function automatic tag_t tag_bit(input int pos);
    tag_t t;
    t      = '0;
    t[pos] = 1'b1;
    return t;
endfunction

// Modified-page opcodes as listed for the arbiter
function automatic logic expect_dirty(input arb_op_t op);
    case (op)
        CCWR, DCWR, DWR, RDMWR, BTRWR: return 1'b1;
        default:                       return 1'b0;
    endcase
endfunction

// Current page load that returns on the edge taking it
task automatic load_page(input page_t p);
    @(posedge clk);
    i_page_we   <= 1'b1;
    i_page_data <= p;
    @(posedge clk);
    i_page_we   <= 1'b0;
endtask

// --------------------------------------------------
// Translation through the map and the bypass
// --------------------------------------------------
task automatic test_translation();
    logic [31:0] rnd;
    page_t       idx;
    vaddr_t      va;
    for (int i = 0; i < (1 << `MMU_PAGE_BITS); i++) begin
        rnd = $urandom;
        idx = page_t'(i);
        @(posedge clk);
        i_map_we       <= 1'b1;
        i_map_index    <= idx;
        i_map_data     <= rnd[9:0];
        model_map[idx] = rnd[9:0];
    end
    @(posedge clk);
    i_map_we <= 1'b0;
    for (int n = 0; n < 64; n++) begin
        rnd = $urandom;
        va  = rnd[19:0];
        @(posedge clk);
        i_vaddr     <= va;
        i_no_paging <= rnd[31];             // About half bypass the map
        @(negedge clk);
        if (rnd[31])
            check_eq("o_physad", 32'(o_physad), 32'(va));
        else
            check_eq("o_physad", 32'(o_physad), 32'({model_map[va[19:10]], va[9:0]}));
    end
endtask

// --------------------------------------------------
// BESM-6 mode from an instruction tag
// --------------------------------------------------
task automatic test_besm6_mode();
    logic [31:0] rnd;
    vaddr_t      va;
    @(posedge clk);
    i_no_paging <= 1'b0;
    i_acc_we    <= 1'b1;                    // Same BESM-6 bit so no BAD_ACC
    i_acc_besm6 <= 1'b1;
    @(posedge clk);
    i_acc_we     <= 1'b0;
    i_fetch_done <= 1'b1;
    i_tag        <= tag_bit(`MMU_TAG_CMD) | tag_bit(`MMU_TAG_BESM6);
    @(posedge clk);
    i_fetch_done <= 1'b0;
    @(negedge clk);
    check_eq("o_besm6_mode", 32'(o_besm6_mode), 32'd1);
    check_eq("o_int_pending", 32'(o_int_pending), 32'd0);
    for (int n = 0; n < 32; n++) begin
        rnd = $urandom;
        va  = rnd[19:0];
        @(posedge clk);
        i_vaddr <= va;
        @(negedge clk);
        check_eq("o_physad", 32'(o_physad),
                 32'({model_map[{5'b0, va[14:10]}], va[9:0]}));    // Short page number
    end
    @(posedge clk);
    i_mode_clr <= 1'b1;
    @(posedge clk);
    i_mode_clr <= 1'b0;
    @(negedge clk);
    check_eq("o_besm6_mode", 32'(o_besm6_mode), 32'd0);
endtask

// --------------------------------------------------
// Used and dirty bits on bus requests
// --------------------------------------------------
task automatic test_request();
    logic [31:0] rnd;
    page_t       p;
    for (int n = 0; n < 8; n++) begin
        rnd = $urandom;
        p   = rnd[9:0];
        load_page(p);
        i_stat_we    <= 1'b1;               // Clear both bits of page p
        i_stat_used  <= 1'b0;
        i_stat_dirty <= 1'b0;
        @(posedge clk);
        i_stat_we <= 1'b0;
        @(negedge clk);
        check_eq("o_used", 32'(o_used), 32'd0);
        check_eq("o_dirty", 32'(o_dirty), 32'd0);
        load_page(~p);                      // Request must bring p back
        i_req       <= 1'b1;
        i_arb_op    <= op_list[n];
        i_vaddr     <= {p, rnd[29:20]};
        i_no_paging <= 1'b1;                // Physical page equals p
        @(posedge clk);
        i_req       <= 1'b0;
        i_no_paging <= 1'b0;
        @(negedge clk);
        check_eq("o_page", 32'(o_page), 32'(p));
        check_eq("o_used", 32'(o_used), 32'd1);
        check_eq("o_dirty", 32'(o_dirty), 32'(expect_dirty(op_list[n])));
    end
endtask

// --------------------------------------------------
// Reprioritize fill from page k to the top
// --------------------------------------------------
task automatic set_reprio(input page_t p, input logic b);
    load_page(p);
    i_reprio_we  <= 1'b1;
    i_reprio_bit <= b;
    @(posedge clk);
    i_reprio_we     <= 1'b0;
    model_reprio[p] = b;
endtask

task automatic test_fill();
    logic [31:0] rnd;
    page_t       k;
    page_t       samples [6];
    int          cycles;
    int          limit;
    rnd        = $urandom;
    k          = 10'd256 + {1'b0, rnd[8:0]};    // Pages on both sides of k
    samples[0] = k - 10'd1;
    samples[1] = k - 10'd7;
    samples[2] = k - 10'd100;
    samples[3] = k;
    samples[4] = k + 10'd3;
    samples[5] = 10'h3ff;
    set_reprio(samples[0], 1'b0);           // Cleared below k
    set_reprio(samples[1], 1'b0);
    set_reprio(samples[2], 1'b0);
    set_reprio(samples[3], 1'b0);           // Cleared at and above k
    set_reprio(samples[4], 1'b0);
    set_reprio(samples[5], 1'b0);
    load_page(k);
    i_fill_start <= 1'b1;
    @(posedge clk);
    i_fill_start <= 1'b0;
    @(negedge clk);
    check_eq("o_fill_busy", 32'(o_fill_busy), 32'd1);
    limit  = 1025 - int'(k);
    cycles = 0;
    while (o_fill_busy) begin
        @(negedge clk);
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: fill still busy after %0d cycles from page %0d", cycles, k);
            stop_run();
        end
    end
    for (int q = int'(k); q < (1 << `MMU_PAGE_BITS); q++)
        model_reprio[page_t'(q)] = 1'b1;
    for (int s = 0; s < 6; s++) begin
        load_page(samples[s]);
        @(negedge clk);
        check_eq("o_reprio", 32'(o_reprio), 32'(model_reprio[samples[s]]));
    end
endtask

// --------------------------------------------------
// Tag-check traps, priority and masks
// --------------------------------------------------
// masks = {no_progtag, no_rtag, no_badacc, no_badop}
task automatic run_tag_case(input logic fetch, input tag_t t, input logic [3:0] masks,
                            input logic jump, input trap_vect_t exp);
    @(posedge clk);
    i_fetch_done <= fetch;
    i_load_done  <= !fetch;
    i_tag        <= t;
    i_flag_jump  <= jump;
    {i_no_progtag, i_no_rtag, i_no_badacc, i_no_badop} <= masks;
    @(posedge clk);
    i_fetch_done <= 1'b0;
    i_load_done  <= 1'b0;
    if (exp != NONE) begin
        model_pending = 1'b1;
        model_vect    = exp;                // Later trap overwrites
    end
    @(negedge clk);
    check_eq("o_int_pending", 32'(o_int_pending), 32'(model_pending));
    check_eq("o_int_vect", 32'(o_int_vect), 32'(model_vect));
endtask

task automatic test_traps();
    tag_t ft;
    tag_t lt;
    @(posedge clk);
    i_acc_we    <= 1'b1;                    // Accumulator tag back to plain
    i_acc_besm6 <= 1'b0;
    i_int_clear <= 1'b1;
    @(posedge clk);
    i_acc_we      <= 1'b0;
    i_int_clear   <= 1'b0;
    model_pending = 1'b0;
    model_vect    = NONE;                   // No trap since reset
    // Fetch matching PINT, not-command, fetch, jump and accumulator checks
    ft = tag_bit(`MMU_TAG_PINT) | tag_bit(`MMU_TAG_NOFETCH) |
         tag_bit(`MMU_TAG_NOJUMP) | tag_bit(`MMU_TAG_BESM6);
    run_tag_case(1'b1, ft, 4'b0000, 1'b1, PINT_INSTR);
    run_tag_case(1'b1, ft, 4'b1000, 1'b1, NOT_CMD);
    ft = ft | tag_bit(`MMU_TAG_CMD);
    run_tag_case(1'b1, ft, 4'b1000, 1'b1, FETCH_PROT);
    ft = ft & ~tag_bit(`MMU_TAG_NOFETCH);
    run_tag_case(1'b1, ft, 4'b1000, 1'b1, JUMP_PROT);
    run_tag_case(1'b1, ft, 4'b1000, 1'b0, BAD_ACC);
    run_tag_case(1'b1, ft, 4'b1010, 1'b0, NONE);        // All masked so the vector holds
    // Load matching PINT, read protect and operand checks
    lt = tag_bit(`MMU_TAG_PINT) | tag_bit(`MMU_TAG_NOLOAD) | tag_bit(`MMU_TAG_BESM6);
    run_tag_case(1'b0, lt, 4'b0000, 1'b0, PINT_DATA);
    run_tag_case(1'b0, lt, 4'b1000, 1'b0, READ_PROT);
    run_tag_case(1'b0, lt, 4'b1100, 1'b0, BAD_OP);
    run_tag_case(1'b0, lt, 4'b1101, 1'b0, NONE);
    @(posedge clk);
    i_int_clear <= 1'b1;
    @(posedge clk);
    i_int_clear   <= 1'b0;
    model_pending = 1'b0;
    @(negedge clk);
    check_eq("o_int_pending", 32'(o_int_pending), 32'd0);
    // Clean instruction word also leaves the mode flag at 0
    run_tag_case(1'b1, tag_bit(`MMU_TAG_CMD), 4'b0000, 1'b0, NONE);
    check_eq("o_besm6_mode", 32'(o_besm6_mode), 32'd0);
endtask

`endif

//--- verification/mmu_tb.sv
// MMU testbench top: clock, reset, DUT instance and test sequence
`default_nettype none
`timescale 1ns/100ps

`include "mmu_config.svh"

module mmu_tb;
    import mmu_pkg::*;

    localparam int unsigned SEED = 32'h6a20afb0;

    // --------------------------------------------------
    // DUT inputs, all idle at time zero
    // --------------------------------------------------
    logic       clk;
    logic       reset        = 1'b1;        // Held for the first 10 cycles
    logic       i_map_we     = 1'b0;
    page_t      i_map_index  = '0;
    page_t      i_map_data   = '0;
    vaddr_t     i_vaddr      = '0;
    logic       i_no_paging  = 1'b0;
    logic       i_req        = 1'b0;
    arb_op_t    i_arb_op     = NOP;
    logic       i_page_we    = 1'b0;
    page_t      i_page_data  = '0;
    logic       i_stat_we    = 1'b0;
    logic       i_stat_used  = 1'b0;
    logic       i_stat_dirty = 1'b0;
    logic       i_reprio_we  = 1'b0;
    logic       i_reprio_bit = 1'b0;
    logic       i_fill_start = 1'b0;
    logic       i_fetch_done = 1'b0;
    logic       i_load_done  = 1'b0;
    tag_t       i_tag        = '0;
    logic       i_acc_we     = 1'b0;
    logic       i_acc_besm6  = 1'b0;
    logic       i_mode_set   = 1'b0;
    logic       i_mode_clr   = 1'b0;
    logic       i_flag_jump  = 1'b0;
    logic       i_no_progtag = 1'b0;        // Trap masks
    logic       i_no_rtag    = 1'b0;
    logic       i_no_badacc  = 1'b0;
    logic       i_no_badop   = 1'b0;
    logic       i_int_clear  = 1'b0;

    // DUT outputs
    vaddr_t     o_physad;
    page_t      o_page;
    logic       o_used;
    logic       o_dirty;
    logic       o_reprio;
    logic       o_fill_busy;
    logic       o_besm6_mode;
    logic       o_int_pending;
    trap_vect_t o_int_vect;

    mmu_top UUT (.*);                       // Port names match the signals above

    `include "mmu_tb_tasks.svh"

    // --------------------------------------------------
    // Clock, 4 ns period
    // --------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(SEED));              // One seed for the whole run
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_eq("o_page", 32'(o_page), 32'd0);                 // Reset state
        check_eq("o_int_pending", 32'(o_int_pending), 32'd0);
        check_eq("o_fill_busy", 32'(o_fill_busy), 32'd0);
        check_eq("o_besm6_mode", 32'(o_besm6_mode), 32'd0);

        test_translation();
        test_besm6_mode();
        test_request();
        test_fill();
        test_traps();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
